// ==== filelist.f ====
+incdir+include
verilog/switch_pkg.sv
verilog/switch_csr.sv
verilog/ingress_router.sv
verilog/rr_packet_arbiter.sv
verilog/egress_crossbar.sv
verilog/packet_switch.sv
testbench/tb_packet_switch.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the packet switch testbench with Verilator, result taken from the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert -j 0 --top-module tb_packet_switch \
    -f filelist.f -o sim_packet_switch 2>&1 | tee "$log" &&
    ./obj_dir/sim_packet_switch 2>&1 | tee -a "$log" ||
    echo "build or run error, CHECKS FAILED" | tee -a "$log"

grep -q "CHECKS FAILED" "$log" && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0

// ==== include/tb_checks.svh ====
// compare tasks and stop helper for the switch testbench, included after importing switch_pkg
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

////////////////////////////////////////////////////////////
// failure report
////////////////////////////////////////////////////////////

// prints the mismatch, the fail banner, then ends the run
task automatic checks_stop(input string test_name, input string exp_s, input string act_s);
    $display("ERROR: %s expected %s actual %s", test_name, exp_s, act_s);
    $display("CHECKS FAILED");
    $fatal(1);
endtask

////////////////////////////////////////////////////////////
// compares
////////////////////////////////////////////////////////////

// full egress beat, valid and last included
task automatic check_beat(input string test_name, input beat_out_t expected,
                          input beat_out_t actual);
    if (actual !== expected) begin
        checks_stop(test_name, $sformatf("%h", expected), $sformatf("%h", actual));
    end
endtask

// register read-back word
task automatic check_csr(input string test_name, input logic [csr_data_width-1:0] expected,
                         input logic [csr_data_width-1:0] actual);
    if (actual !== expected) begin
        checks_stop(test_name, $sformatf("%h", expected), $sformatf("%h", actual));
    end
endtask

// per-port bits such as ready or valid
task automatic check_vec(input string test_name, input port_vec_t expected,
                         input port_vec_t actual);
    if (actual !== expected) begin
        checks_stop(test_name, $sformatf("%b", expected), $sformatf("%b", actual));
    end
endtask

`endif

// ==== testbench/tb_packet_switch.sv ====
// self-checking testbench for packet_switch that is compiled from filelist.f and run by run_sim.sh
`timescale 1ns/1ps

module tb_packet_switch
    import switch_pkg::*;
();

    `include "tb_checks.svh"

    // expected egress beat tagged with its packet and source ingress
    typedef struct packed {
        logic [3:0] pkt;
        port_idx_t  src;
        beat_out_t  beat;
    } exp_beat_t;

    ////////////////////////////////////////////////////////////
    // packet table
    ////////////////////////////////////////////////////////////

    localparam int n_pkts  = 9;
    localparam int max_len = 5;

    // columns are name, source, dest, beats, earliest start cycle
    // rr rows race into egress 2
    // reset_hold waits on disabled egress 3
    string pkt_name  [n_pkts] = '{"reset_hold", "route_0_to_1", "route_3_to_0", "rr_first",
        "rr_second", "rr_third", "rr_fourth", "route_0_to_1_b", "route_3_to_3"};
    int    pkt_src   [n_pkts] = '{0, 0, 3, 1, 2, 1, 2, 0, 3};
    int    pkt_dst   [n_pkts] = '{3, 1, 0, 2, 2, 2, 2, 1, 3};
    int    pkt_len   [n_pkts] = '{3, 4, 5, 3, 2, 4, 3, 2, 2};
    int    pkt_start [n_pkts] = '{0, 30, 30, 30, 30, 30, 30, 30, 30};

    logic                      clk = 1'b0;
    logic                      reset = 1'b1;
    logic                      chipselect;
    logic                      write;
    logic                      read;
    logic [csr_addr_width-1:0] address;
    logic [csr_data_width-1:0] writedata;
    logic [csr_data_width-1:0] readdata;
    beat_in_t                  ingress [n_ports];
    port_vec_t                 ingress_ready;
    beat_out_t                 egress [n_ports];
    port_vec_t                 egress_ready;

    logic [data_width-1:0]     payload [n_pkts][max_len];
    exp_beat_t                 expected_q [n_ports][$];
    port_vec_t                 held = '0;
    int                        cycle;
    logic                      traffic_done;
    // payload stream and a second stream for egress ready
    int                        payload_seed = 32'h6732_4e09;
    int                        ready_seed   = ~32'h6732_4e09;

    packet_switch dut0 (
        .clk           (clk),
        .reset         (reset),
        .chipselect    (chipselect),
        .write         (write),
        .read          (read),
        .address       (address),
        .writedata     (writedata),
        .readdata      (readdata),
        .ingress       (ingress),
        .ingress_ready (ingress_ready),
        .egress        (egress),
        .egress_ready  (egress_ready)
    );

    initial begin
        forever begin
            #10 clk = ~clk;
        end
    end

    // counts cycles since reset release for packet start times
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cycle <= 0;
        end else begin
            cycle <= cycle + 1;
        end
    end

    function automatic port_vec_t egress_valids();
        port_vec_t v;
        for (int e = 0; e < n_ports; e++) begin
            v[e] = egress[e].valid;
        end
        return v;
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    // random payloads queued per dest in expected arrival order
    task automatic build_expected();
        exp_beat_t item;
        for (int p = 0; p < n_pkts; p++) begin
            for (int b = 0; b < pkt_len[p]; b++) begin
                payload[p][b]   = data_width'($random(payload_seed));
                item.pkt        = 4'(p);
                item.src        = port_idx_t'(pkt_src[p]);
                item.beat.valid = 1'b1;
                item.beat.last  = (b == pkt_len[p] - 1);
                item.beat.data  = payload[p][b];
                expected_q[pkt_dst[p]].push_back(item);
            end
        end
    endtask

    task automatic csr_access(input logic wr, input logic [csr_addr_width-1:0] addr,
                              input logic [csr_data_width-1:0] data);
        @(posedge clk);
        #2;
        chipselect = 1'b1;
        write      = wr;
        read       = !wr;
        address    = addr;
        writedata  = data;
        @(posedge clk);
        #2;
        chipselect = 1'b0;
        write      = 1'b0;
        read       = 1'b0;
        // read-back registered on the edge just passed
        @(negedge clk);
    endtask

    // drives one source through its table rows in order
    // each beat held until taken
    task automatic drive_ingress(input int src);
        @(posedge clk);
        #2;
        for (int p = 0; p < n_pkts; p++) begin
            if (pkt_src[p] == src) begin
                while (cycle < pkt_start[p]) begin
                    @(posedge clk);
                    #2;
                end
                for (int b = 0; b < pkt_len[p]; b++) begin
                    ingress[src].valid = 1'b1;
                    ingress[src].last  = (b == pkt_len[p] - 1);
                    ingress[src].dest  = port_idx_t'(pkt_dst[p]);
                    ingress[src].data  = payload[p][b];
                    @(negedge clk);
                    while (!ingress_ready[src]) begin
                        @(negedge clk);
                    end
                    @(posedge clk);
                    #2;
                end
                ingress[src].valid = 1'b0;
            end
        end
    endtask

    initial begin
        ingress      = '{default: '0};
        traffic_done = 1'b0;
        @(negedge reset);
        fork
            drive_ingress(0);
            drive_ingress(1);
            drive_ingress(2);
            drive_ingress(3);
        join
        traffic_done = 1'b1;
    end

    initial begin
        egress_ready = '0;
        forever begin
            @(posedge clk);
            #2;
            egress_ready = port_vec_t'($random(ready_seed));
        end
    end

    ////////////////////////////////////////////////////////////
    // scoreboard
    ////////////////////////////////////////////////////////////

    // a beat seen at the falling edge transfers on the next rising edge
    task automatic watch_egress(input int e);
        exp_beat_t front;
        port_vec_t src_bit;
        if ((egress[e].valid || held[e]) && expected_q[e].size() == 0) begin
            abort_run($sformatf("egress %0d sent a beat that no packet was routed to", e));
        end else if (egress[e].valid || held[e]) begin
            front   = expected_q[e][0];
            src_bit = port_vec_t'(1) << front.src;
            // a stalled beat must still be the same front beat
            check_beat(pkt_name[front.pkt], front.beat, egress[e]);
            check_vec(pkt_name[front.pkt], egress_ready[e] ? src_bit : '0,
                      ingress_ready & src_bit);
            held[e] = !egress_ready[e];
            if (egress_ready[e]) begin
                void'(expected_q[e].pop_front());
            end
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            for (int e = 0; e < n_ports; e++) begin
                watch_egress(e);
            end
        end
    end

    // limit is 8 cycles per table beat plus a setup margin
    initial begin
        int limit;
        limit = 200;
        for (int p = 0; p < n_pkts; p++) begin
            limit += pkt_len[p] * 8;
        end
        #(limit * 20);
        $display("timeout after %0d cycles, traffic did not drain", limit);
        $display("CHECKS FAILED");
        $fatal(1);
    end

    initial begin
        chipselect = 1'b0;
        write      = 1'b0;
        read       = 1'b0;
        address    = '0;
        writedata  = '0;
        build_expected();
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;

        // ingress 0 already drives its first beat toward disabled egress 3
        repeat (2) @(posedge clk);
        @(negedge clk);
        if (!ingress[0].valid) begin
            abort_run("ingress 0 was not driving a beat during the reset check");
        end
        check_csr("reset_state", '0, readdata);
        check_vec("reset_state", '0, egress_valids());
        check_vec("reset_state", '0, ingress_ready);

        csr_access(1'b1, csr_mask_addr, 32'h0000_0005);
        csr_access(1'b0, csr_mask_addr, '0);
        check_csr("csr_write_read", 32'h0000_0005, readdata);
        // stray write to an undecoded address
        csr_access(1'b1, 8'h04, 32'h0000_000f);
        csr_access(1'b0, csr_mask_addr, '0);
        check_csr("csr_other_addr", 32'h0000_0005, readdata);
        check_vec("disabled_hold", '0, egress_valids());
        check_vec("disabled_hold", '0, ingress_ready);

        // with all ports on the held packet and table traffic flow
        csr_access(1'b1, csr_mask_addr, 32'h0000_000f);
        wait (traffic_done);
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_vec("drain", '0, egress_valids());
        if (expected_q[0].size() + expected_q[1].size() + expected_q[2].size()
                + expected_q[3].size() == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("expected beats left in the egress queues after traffic ended");
            $display("CHECKS FAILED");
            $fatal(1);
        end
    end

endmodule

// ==== verilog/packet_switch.sv ====
// four-port packet switch top, wires the mask register, router, arbiters and crossbar
`timescale 1ns/1ps

module packet_switch
    import switch_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,

    // control bus
    input  logic                      chipselect,
    input  logic                      write,
    input  logic                      read,
    input  logic [csr_addr_width-1:0] address,
    input  logic [csr_data_width-1:0] writedata,
    output logic [csr_data_width-1:0] readdata,

    // ingress streams
    input  beat_in_t                  ingress [n_ports],
    output port_vec_t                 ingress_ready,

    // egress streams
    output beat_out_t                 egress [n_ports],
    input  port_vec_t                 egress_ready
);

    port_vec_t   egress_enable;
    req_matrix_t request;
    req_matrix_t grant;
    // ready seen by arbiters and router, after the enable mask
    port_vec_t   port_ready;
    // last flags gathered for the arbiters
    port_vec_t   ingress_last;

    ////////////////////////////////////////////////////////////
    // input side
    ////////////////////////////////////////////////////////////

    switch_csr csr0 (
        .clk           (clk),
        .reset         (reset),
        .chipselect    (chipselect),
        .write         (write),
        .read          (read),
        .address       (address),
        .writedata     (writedata),
        .readdata      (readdata),
        .egress_enable (egress_enable)
    );

    ingress_router router0 (
        .ingress       (ingress),
        .grant         (grant),
        .port_ready    (port_ready),
        .request       (request),
        .ingress_ready (ingress_ready)
    );

    ////////////////////////////////////////////////////////////
    // one arbiter per egress
    ////////////////////////////////////////////////////////////

    for (genvar g = 0; g < n_ports; g++) begin : g_arb
        assign ingress_last[g] = ingress[g].last;

        // row g of request in, row g of grant out
        rr_packet_arbiter arb (
            .clk         (clk),
            .reset       (reset),
            .request_row (request[g]),
            .port_ready  (port_ready[g]),
            .last_in     (ingress_last),
            .grant_row   (grant[g])
        );
    end

    // output side
    egress_crossbar xbar0 (
        .ingress       (ingress),
        .grant         (grant),
        .egress_enable (egress_enable),
        .egress_ready  (egress_ready),
        .egress        (egress),
        .port_ready    (port_ready)
    );

endmodule

// ==== verilog/egress_crossbar.sv ====
// per-egress beat select from the granted ingress, with enable mask and egress back-pressure
`timescale 1ns/1ps

module egress_crossbar
    import switch_pkg::*;
(
    input  beat_in_t    ingress [n_ports],
    input  req_matrix_t grant,
    input  port_vec_t   egress_enable,
    input  port_vec_t   egress_ready,
    output beat_out_t   egress [n_ports],
    output port_vec_t   port_ready
);

    ////////////////////////////////////////////////////////////
    // beat select
    ////////////////////////////////////////////////////////////

    // grant rows are one-hot or zero, so and-or select is enough
    // zero grant leaves data and last at zero
    always_comb begin
        for (int e = 0; e < n_ports; e++) begin
            egress[e].data = '0;
            egress[e].last = 1'b0;
            for (int i = 0; i < n_ports; i++) begin
                if (grant[e][i]) begin
                    egress[e].data = egress[e].data | ingress[i].data;
                    egress[e].last = egress[e].last | ingress[i].last;
                end
            end
        end
    end

    // valid needs an owner and an enabled port
    // grant already implies the owner's valid
    always_comb begin
        for (int e = 0; e < n_ports; e++) begin
            egress[e].valid = (|grant[e]) && egress_enable[e];
        end
    end

    ////////////////////////////////////////////////////////////
    // back-pressure
    ////////////////////////////////////////////////////////////

    // disabled port reports not ready
    // source then holds its beat instead of dropping it
    always_comb begin
        for (int e = 0; e < n_ports; e++) begin
            port_ready[e] = egress_ready[e] && egress_enable[e];
        end
    end

endmodule

// ==== verilog/rr_packet_arbiter.sv ====
// round-robin arbiter that keeps its winner until the last beat of the packet and is instantiated once per egress
`timescale 1ns/1ps

module rr_packet_arbiter
    import switch_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  port_vec_t request_row,
    input  logic      port_ready,
    input  port_vec_t last_in,
    output port_vec_t grant_row
);

    // rotating start point for the search
    port_idx_t pointer;
    // owner held across beats and stalls
    logic      locked;
    port_idx_t lock_idx;

    // idle choice
    logic      pick_valid;
    port_idx_t pick_idx;

    // current owner and its handshake
    port_idx_t win_idx;
    logic      xfer;
    logic      xfer_last;

    ////////////////////////////////////////////////////////////
    // idle search
    ////////////////////////////////////////////////////////////

    // first requester at or after pointer
    // walk offsets high to low so the smallest offset wins
    always_comb begin
        port_idx_t cand;
        pick_valid = 1'b0;
        pick_idx   = pointer;
        for (int k = n_ports - 1; k >= 0; k--) begin
            cand = pointer + port_idx_t'(k);
            if (request_row[cand]) begin
                pick_valid = 1'b1;
                pick_idx   = cand;
            end
        end
    end

    // locked grant stays on its owner
    // and is still masked by the owner's valid
    always_comb begin
        if (locked) begin
            grant_row = request_row & (port_vec_t'(1) << lock_idx);
        end else if (pick_valid) begin
            grant_row = port_vec_t'(1) << pick_idx;
        end else begin
            grant_row = '0;
        end
    end

    assign win_idx   = locked ? lock_idx : pick_idx;
    // port_ready already carries the enable bit
    assign xfer      = (|grant_row) && port_ready;
    assign xfer_last = xfer && last_in[win_idx];

    ////////////////////////////////////////////////////////////
    // lock and pointer
    ////////////////////////////////////////////////////////////

    // any granted cycle that is not the final beat locks the owner
    // covers mid-packet beats and stalled first beats alike
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pointer  <= '0;
            locked   <= 1'b0;
            lock_idx <= '0;
        end else if (|grant_row) begin
            if (xfer_last) begin
                locked  <= 1'b0;
                // next search starts past the winner
                pointer <= win_idx + port_idx_t'(1);
            end else begin
                locked   <= 1'b1;
                lock_idx <= win_idx;
            end
        end
    end

    // a finished owner yields to any ingress left waiting
    a_rr_rotate : assert property (
        @(posedge clk) disable iff (reset)
        (xfer_last && ((request_row & ~grant_row) != '0)) |=>
            ((grant_row & $past(grant_row)) == '0));

    // no other ingress slips in before the last beat transfers
    a_grant_held : assert property (
        @(posedge clk) disable iff (reset)
        ((|grant_row) && !xfer_last) |=>
            ((grant_row == $past(grant_row)) || (grant_row == '0)));

endmodule

// ==== verilog/ingress_router.sv ====
// decodes ingress destinations into egress requests and folds grants back into ingress ready
`timescale 1ns/1ps

module ingress_router
    import switch_pkg::*;
(
    input  beat_in_t    ingress [n_ports],
    input  req_matrix_t grant,
    input  port_vec_t   port_ready,
    output req_matrix_t request,
    output port_vec_t   ingress_ready
);

    ////////////////////////////////////////////////////////////
    // request decode
    ////////////////////////////////////////////////////////////

    // each valid ingress raises exactly one bit
    // row picked by dest, column by ingress index
    always_comb begin
        request = '0;
        for (int i = 0; i < n_ports; i++) begin
            if (ingress[i].valid) begin
                request[ingress[i].dest][i] = 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // ready merge
    ////////////////////////////////////////////////////////////

    // ingress i ready only when its egress grants it
    // and that egress takes the beat this cycle
    // disabled egress keeps port_ready low, so traffic holds
    always_comb begin
        ingress_ready = '0;
        for (int e = 0; e < n_ports; e++) begin
            for (int i = 0; i < n_ports; i++) begin
                if (grant[e][i] && port_ready[e]) begin
                    ingress_ready[i] = 1'b1;
                end
            end
        end
    end

    // column check across the four arbiters
    // an ingress never owned by two egresses at once
    always_comb begin
        port_vec_t column;
        for (int i = 0; i < n_ports; i++) begin
            for (int e = 0; e < n_ports; e++) begin
                column[e] = grant[e][i];
            end
            a_single_owner : assert final ($onehot0(column));
        end
    end

endmodule

// ==== verilog/switch_csr.sv ====
// egress enable mask register on the control bus, with registered read-back
`timescale 1ns/1ps

module switch_csr
    import switch_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      chipselect,
    input  logic                      write,
    input  logic                      read,
    input  logic [csr_addr_width-1:0] address,
    input  logic [csr_data_width-1:0] writedata,
    output logic [csr_data_width-1:0] readdata,
    output port_vec_t                 egress_enable
);

    // single register, so address decode is one compare
    logic hit;

    assign hit = chipselect && (address == csr_mask_addr);

    ////////////////////////////////////////////////////////////
    // enable mask
    ////////////////////////////////////////////////////////////

    // all egress ports start disabled
    // new mask seen by traffic right after the write edge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            egress_enable <= '0;
        end else if (hit && write) begin
            egress_enable <= writedata[n_ports-1:0];
        end
    end

    // read-back, zero extended, valid one cycle after the strobe
    // held until the next read of the mask
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            readdata <= '0;
        end else if (hit && read) begin
            readdata <= csr_data_width'(egress_enable);
        end
    end

    // bus master never issues read and write together
    a_no_rw_collision : assert property (
        @(posedge clk) disable iff (reset) chipselect |-> !(read && write));

endmodule

// ==== verilog/switch_pkg.sv ====
// shared sizes, stream beat structs and request/grant matrix types, imported by every switch block
package switch_pkg;

    ////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////

    // ingress and egress port count
    localparam int n_ports    = 4;
    // beat payload width
    localparam int data_width = 16;
    // bits needed to name one port
    localparam int idx_width  = 2;

    // avalon-mm style register bus
    localparam int csr_data_width = 32;
    localparam int csr_addr_width = 8;

    // egress enable mask lives at the only decoded address
    localparam logic [csr_addr_width-1:0] csr_mask_addr = '0;

    ////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////

    // one port index
    typedef logic [idx_width-1:0] port_idx_t;

    // one bit per port, used for mask, readies and grant rows
    typedef logic [n_ports-1:0] port_vec_t;

    // beat arriving at an ingress port, 20 bits
    typedef struct packed {
        logic                  valid;
        logic                  last;
        port_idx_t             dest;
        logic [data_width-1:0] data;
    } beat_in_t;

    // beat leaving an egress port, 18 bits
    // dest is dropped, the port itself says where it went
    typedef struct packed {
        logic                  valid;
        logic                  last;
        logic [data_width-1:0] data;
    } beat_out_t;

    // row e holds the ingress bits aimed at egress e
    // same shape for requests and grants
    typedef logic [n_ports-1:0][n_ports-1:0] req_matrix_t;

endpackage
